// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --timescale 1ns/10ps
TOP       := tb_trinomial_evaluator
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
source/mac_types_pkg.sv
source/mac_ctrl_pkg.sv
source/mac_unit.sv
source/mac_control_unit.sv
source/trinomial_evaluator.sv
verification/tb_trinomial_evaluator.sv

// ==== source/mac_control_unit.sv ====
`timescale 1ns/10ps

module mac_control_unit (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mac_types_pkg::poly_request_t req,
	output logic busy,
	output mac_ctrl_pkg::mac_cmd_t cmd,
	input mac_types_pkg::result_t acc,
	output logic result_valid,
	output mac_types_pkg::result_t result
);

	mac_ctrl_pkg::seq_state_t state;
	mac_ctrl_pkg::seq_state_t state_next;
	mac_types_pkg::poly_request_t req_q;
	mac_ctrl_pkg::mac_cmd_t cmd_next;
	logic accept;

	//////////////////////////////
	// Command builders
	//////////////////////////////

	// First Horner step, a*x + b
	function automatic mac_ctrl_pkg::mac_cmd_t coeff_step(
		input mac_types_pkg::poly_request_t r
	);
		mac_ctrl_pkg::mac_cmd_t c;
		c.enable = 1'b1;
		c.mul_src = mac_ctrl_pkg::MUL_SRC_COEFF;
		c.coeff = r.a;
		c.x = r.x;
		c.addend = r.b;
		c.mode = r.mode;
		return c;
	endfunction

	// Second Horner step, acc*x + c
	function automatic mac_ctrl_pkg::mac_cmd_t acc_step(
		input mac_types_pkg::poly_request_t r
	);
		mac_ctrl_pkg::mac_cmd_t c;
		c.enable = 1'b1;
		c.mul_src = mac_ctrl_pkg::MUL_SRC_ACC;
		c.coeff = '0;  // Not used with accumulator feedback
		c.x = r.x;
		c.addend = r.c;
		c.mode = r.mode;
		return c;
	endfunction

	//////////////////////////////
	// Handshake
	//////////////////////////////

	assign accept = req_valid && (state == mac_ctrl_pkg::IDLE);
	assign busy = (state != mac_ctrl_pkg::IDLE);

	// Request held for both datapath steps
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
		end
	end

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			mac_ctrl_pkg::IDLE: begin
				if (accept) begin
					state_next = mac_ctrl_pkg::MUL_WITH_INPUT;
				end
			end
			mac_ctrl_pkg::MUL_WITH_INPUT: begin
				state_next = mac_ctrl_pkg::MUL_WITH_ACC;
			end
			mac_ctrl_pkg::MUL_WITH_ACC: begin
				state_next = mac_ctrl_pkg::OUTPUT_FINAL;
			end
			mac_ctrl_pkg::OUTPUT_FINAL: begin
				state_next = mac_ctrl_pkg::IDLE;
			end
			default: begin
				state_next = mac_ctrl_pkg::IDLE;
			end
		endcase
	end

	always_comb begin
		cmd_next = '0;  // Idle datapath holds acc
		case (state)
			mac_ctrl_pkg::MUL_WITH_INPUT: begin
				cmd_next = coeff_step(req_q);
			end
			mac_ctrl_pkg::MUL_WITH_ACC: begin
				cmd_next = acc_step(req_q);
			end
			default: begin
				cmd_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= mac_ctrl_pkg::IDLE;
			cmd <= '0;
			result_valid <= 1'b0;
		end else begin
			state <= state_next;
			cmd <= cmd_next;  // Datapath sees it one cycle later
			result_valid <= (state == mac_ctrl_pkg::OUTPUT_FINAL);  // Final acc lands here too
		end
	end

	//////////////////////////////
	// Result
	//////////////////////////////

	assign result = result_valid ? acc : '0;

endmodule

// ==== source/mac_ctrl_pkg.sv ====
package mac_ctrl_pkg;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	typedef enum logic [1:0] {
		IDLE           = 2'b00,
		MUL_WITH_INPUT = 2'b01,  // a*x + b
		MUL_WITH_ACC   = 2'b10,  // acc*x + c
		OUTPUT_FINAL   = 2'b11
	} seq_state_t;

	//////////////////////////////
	// Datapath command
	//////////////////////////////

	typedef enum logic {
		MUL_SRC_COEFF = 1'b0,  // Latched coefficient a
		MUL_SRC_ACC   = 1'b1   // Accumulator feedback
	} mul_src_t;

	// One multiply-accumulate step
	typedef struct packed {
		logic enable;
		mul_src_t mul_src;
		mac_types_pkg::operand_t coeff;
		mac_types_pkg::operand_t x;
		mac_types_pkg::operand_t addend;
		mac_types_pkg::arith_mode_t mode;
	} mac_cmd_t;

endpackage

// ==== source/mac_types_pkg.sv ====
package mac_types_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int OPERAND_WIDTH = 8;
	localparam int RESULT_WIDTH = 17;  // Low bits of the trinomial value

	//////////////////////////////
	// Data types
	//////////////////////////////

	typedef logic [OPERAND_WIDTH-1:0] operand_t;  // One coefficient or argument
	typedef logic [RESULT_WIDTH-1:0] result_t;    // Accumulator and final result

	typedef enum logic {
		MODE_UNSIGNED = 1'b0,
		MODE_SIGNED   = 1'b1  // Two's complement operands
	} arith_mode_t;

	// One complete request, taken in a single beat
	typedef struct packed {
		operand_t a;
		operand_t b;
		operand_t c;
		operand_t x;
		arith_mode_t mode;
	} poly_request_t;

endpackage

// ==== source/mac_unit.sv ====
`timescale 1ns/10ps

module mac_unit (
	input logic clk,
	input logic reset,
	input mac_ctrl_pkg::mac_cmd_t cmd,
	output mac_types_pkg::result_t acc
);

	localparam int EXT_WIDTH = mac_types_pkg::RESULT_WIDTH - mac_types_pkg::OPERAND_WIDTH;
	localparam int SIGN_BIT = mac_types_pkg::OPERAND_WIDTH - 1;

	mac_types_pkg::result_t coeff_ext;
	mac_types_pkg::result_t x_ext;
	mac_types_pkg::result_t addend_ext;
	mac_types_pkg::result_t multiplicand;
	mac_types_pkg::result_t product;
	mac_types_pkg::result_t acc_next;

	//////////////////////////////
	// Operand extension
	//////////////////////////////

	// Widen an 8-bit operand to accumulator width
	function automatic mac_types_pkg::result_t extend(
		input mac_types_pkg::operand_t value,
		input mac_types_pkg::arith_mode_t mode
	);
		logic fill;
		if (mode == mac_types_pkg::MODE_SIGNED) begin
			fill = value[SIGN_BIT];
		end else begin
			fill = 1'b0;
		end
		return {{EXT_WIDTH{fill}}, value};
	endfunction

	assign coeff_ext = extend(cmd.coeff, cmd.mode);
	assign x_ext = extend(cmd.x, cmd.mode);
	assign addend_ext = extend(cmd.addend, cmd.mode);

	//////////////////////////////
	// Multiply and add
	//////////////////////////////

	always_comb begin
		if (cmd.mul_src == mac_ctrl_pkg::MUL_SRC_ACC) begin
			multiplicand = acc;  // Horner feedback
		end else begin
			multiplicand = coeff_ext;
		end
	end

	// Both sides at 17 bits, so the product wraps modulo 2^17
	assign product = multiplicand * x_ext;
	assign acc_next = product + addend_ext;

	//////////////////////////////
	// Accumulator
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc <= '0;
		end else if (cmd.enable) begin
			acc <= acc_next;
		end
	end

endmodule

// ==== source/trinomial_evaluator.sv ====
`timescale 1ns/10ps

module trinomial_evaluator (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input mac_types_pkg::poly_request_t req,
	output logic busy,
	output logic result_valid,
	output mac_types_pkg::result_t result
);

	mac_ctrl_pkg::mac_cmd_t cmd;  // Sequencer to datapath
	mac_types_pkg::result_t acc;  // Datapath back to sequencer

	mac_control_unit control_unit (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.busy(busy),
		.cmd(cmd),
		.acc(acc),
		.result_valid(result_valid),
		.result(result)
	);

	mac_unit datapath (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.acc(acc)
	);

endmodule

// ==== verification/tb_trinomial_evaluator.sv ====
`timescale 1ns/10ps

module tb_trinomial_evaluator;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 5;
	localparam int LATENCY = 3;
	localparam int TIMEOUT_CYCLES = 20;
	localparam int RANDOM_COUNT = 20;
	localparam int B2B_COUNT = 8;

	logic clk;
	logic reset;
	logic req_valid;
	mac_types_pkg::poly_request_t req;
	logic busy;
	logic result_valid;
	mac_types_pkg::result_t result;
	logic [31:0] lfsr;

	trinomial_evaluator uut (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.busy(busy),
		.result_valid(result_valid),
		.result(result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic feedback;
		feedback = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
		return {s[30:0], feedback};
	endfunction

	function automatic mac_types_pkg::operand_t random_operand();
		mac_types_pkg::operand_t value;
		value = '0;
		for (int i = 0; i < mac_types_pkg::OPERAND_WIDTH; i++) begin
			lfsr = lfsr_step(lfsr);
			value = {value[6:0], lfsr[0]};  // One step per bit
		end
		return value;
	endfunction

	function automatic mac_types_pkg::poly_request_t make_request(
		input mac_types_pkg::operand_t a,
		input mac_types_pkg::operand_t b,
		input mac_types_pkg::operand_t c,
		input mac_types_pkg::operand_t x,
		input mac_types_pkg::arith_mode_t mode
	);
		mac_types_pkg::poly_request_t r;
		r.a = a;
		r.b = b;
		r.c = c;
		r.x = x;
		r.mode = mode;
		return r;
	endfunction

	function automatic mac_types_pkg::poly_request_t random_request(
		input mac_types_pkg::arith_mode_t mode
	);
		mac_types_pkg::poly_request_t r;
		r.a = random_operand();
		r.b = random_operand();
		r.c = random_operand();
		r.x = random_operand();
		r.mode = mode;
		return r;
	endfunction

	// Exact a*x^2 + b*x + c in 32 bits, then the low 17 bits
	function automatic mac_types_pkg::result_t expected_result(
		input mac_types_pkg::poly_request_t r
	);
		int a;
		int b;
		int c;
		int x;
		int full;
		if (r.mode == mac_types_pkg::MODE_SIGNED) begin
			a = int'($signed(r.a));
			b = int'($signed(r.b));
			c = int'($signed(r.c));
			x = int'($signed(r.x));
		end else begin
			a = int'(r.a);
			b = int'(r.b);
			c = int'(r.c);
			x = int'(r.x);
		end
		full = a * x * x + b * x + c;
		return full[mac_types_pkg::RESULT_WIDTH-1:0];
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_result(input string name, input mac_types_pkg::result_t expected,
		input mac_types_pkg::result_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual));
		end
	endtask

	//////////////////////////////
	// Driver
	//////////////////////////////

	task automatic wait_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy) begin
			if (cycles >= TIMEOUT_CYCLES) begin
				fail_run("Timeout: busy never fell, the DUT stayed occupied");
			end else begin
				wait_cycle();
				cycles++;
			end
		end
	endtask

	// Starts just after the acceptance edge and ends in the result pulse cycle
	task automatic await_result(input mac_types_pkg::poly_request_t r);
		mac_types_pkg::result_t expected;
		int cycles;
		expected = expected_result(r);
		cycles = 0;
		while (!result_valid) begin
			check_flag("busy", 1'b1, busy);
			check_result("result", '0, result);  // Gated off without valid
			if (cycles >= TIMEOUT_CYCLES) begin
				fail_run("Timeout: result_valid never rose after an accepted request");
			end else begin
				wait_cycle();
				cycles++;
			end
		end
		if (cycles != LATENCY) begin
			fail_run($sformatf("result_valid rose %0d cycles after acceptance instead of %0d",
				cycles, LATENCY));
		end
		check_flag("busy", 1'b0, busy);  // Falls together with the pulse
		check_result("result", expected, result);
	endtask

	task automatic send_request(input mac_types_pkg::poly_request_t r);
		wait_idle();
		req = r;
		req_valid = 1'b1;
		wait_cycle();  // Acceptance edge
		req_valid = 1'b0;
		await_result(r);
		wait_cycle();
		check_flag("result_valid", 1'b0, result_valid);  // One cycle pulse
		check_result("result", '0, result);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic reset_test();
		for (int i = 0; i < 4; i++) begin
			check_flag("busy", 1'b0, busy);
			check_flag("result_valid", 1'b0, result_valid);
			check_result("result", '0, result);
			wait_cycle();
		end
	endtask

	task automatic unsigned_test();
		send_request(make_request(8'h00, 8'h00, 8'h00, 8'h00, mac_types_pkg::MODE_UNSIGNED));
		send_request(make_request(8'h00, 8'h00, 8'h2a, 8'hc3, mac_types_pkg::MODE_UNSIGNED));
		send_request(make_request(8'h11, 8'h22, 8'h33, 8'h01, mac_types_pkg::MODE_UNSIGNED));
		send_request(make_request(8'hff, 8'hff, 8'hff, 8'hff, mac_types_pkg::MODE_UNSIGNED));
		send_request(make_request(8'h80, 8'h00, 8'h01, 8'hfe, mac_types_pkg::MODE_UNSIGNED));
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			send_request(random_request(mac_types_pkg::MODE_UNSIGNED));
		end
	endtask

	task automatic signed_test();
		send_request(make_request(8'h80, 8'hff, 8'hfb, 8'hfd, mac_types_pkg::MODE_SIGNED));
		send_request(make_request(8'h80, 8'h80, 8'h80, 8'h80, mac_types_pkg::MODE_SIGNED));
		send_request(make_request(8'h7f, 8'h80, 8'h7f, 8'h80, mac_types_pkg::MODE_SIGNED));
		send_request(make_request(8'hff, 8'hff, 8'hff, 8'hff, mac_types_pkg::MODE_SIGNED));
		send_request(make_request(8'h10, 8'hf0, 8'h00, 8'h7f, mac_types_pkg::MODE_SIGNED));
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			send_request(random_request(mac_types_pkg::MODE_SIGNED));
		end
	endtask

	// Accumulator keeps a nonzero value that must stay off the output
	task automatic timing_test();
		send_request(make_request(8'h01, 8'h02, 8'h03, 8'h04, mac_types_pkg::MODE_UNSIGNED));
		for (int i = 0; i < 3; i++) begin
			wait_cycle();
			check_flag("busy", 1'b0, busy);
			check_flag("result_valid", 1'b0, result_valid);
			check_result("result", '0, result);
		end
	endtask

	task automatic busy_gating_test();
		mac_types_pkg::poly_request_t first;
		mac_types_pkg::poly_request_t second;
		first = random_request(mac_types_pkg::MODE_UNSIGNED);
		second = random_request(mac_types_pkg::MODE_SIGNED);
		while (expected_result(second) == expected_result(first)) begin
			second = random_request(mac_types_pkg::MODE_SIGNED);  // Results must differ
		end
		wait_idle();
		req = first;
		req_valid = 1'b1;
		wait_cycle();
		req = second;  // Held while busy
		await_result(first);
		wait_cycle();  // Second request taken here
		req_valid = 1'b0;
		check_flag("result_valid", 1'b0, result_valid);
		await_result(second);
		wait_cycle();
		check_flag("result_valid", 1'b0, result_valid);
	endtask

	task automatic back_to_back_test();
		mac_types_pkg::poly_request_t r;
		r = random_request(mac_types_pkg::MODE_UNSIGNED);
		wait_idle();
		req = r;
		req_valid = 1'b1;
		wait_cycle();
		for (int i = 0; i < B2B_COUNT; i++) begin
			req_valid = 1'b0;
			await_result(r);
			if (i < B2B_COUNT - 1) begin
				r = random_request(mac_types_pkg::arith_mode_t'((i + 1) % 2));
				req = r;
				req_valid = 1'b1;  // Issued in the pulse cycle
			end
			wait_cycle();
			check_flag("result_valid", 1'b0, result_valid);
			check_flag("busy", i < B2B_COUNT - 1, busy);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		lfsr = 32'habf29167;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		reset_test();
		unsigned_test();
		signed_test();
		timing_test();
		busy_gating_test();
		back_to_back_test();
		$display("Regression passed");
		$finish;
	end

endmodule
